// File: hdl/decode_stage.sv
module decode_stage import la_pipe_pkg::*, la_isa_pkg::*; (
    input  logic            clk,
    input  logic            resetn,
    fetch_link_if.consumer  in,
    exec_link_if.producer   out,
    bypass_if.consumer      byp,
    output logic            br_redirect,
    output logic [XLEN-1:0] br_target
);

    logic            valid;
    la_inst_u        inst;
    logic [XLEN-1:0] pc;

    logic is_add, is_sub, is_and, is_or, is_xor;
    logic is_addi, is_lu12i, is_beq, is_bne, is_b;
    logic is_3r, src_is_rd, br_cond, exec_fire;

    logic [REG_AW-1:0] rd, rj, rk;
    logic [REG_AW-1:0] raddr1, raddr2;
    logic [XLEN-1:0]   rdata1, rdata2;
    logic [XLEN-1:0]   rj_value, rkd_value;
    logic              fwd1, fwd2;

    logic [XLEN-1:0] simm12, imm20, offs16, offs26;
    logic [25:0]     i26;

    assign in.allowin = !valid || out.allowin;

    // wrong-path word dropped on redirect
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid <= 1'b0;
        end else if (br_redirect) begin
            valid <= 1'b0;
        end else if (in.allowin) begin
            valid <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid && in.allowin) begin
            inst <= in.inst;
            pc   <= in.pc;
        end
    end

    // one word, read through each format view
    assign is_add   = inst.fmt_3r.opcode == OP_ADD_W;
    assign is_sub   = inst.fmt_3r.opcode == OP_SUB_W;
    assign is_and   = inst.fmt_3r.opcode == OP_AND;
    assign is_or    = inst.fmt_3r.opcode == OP_OR;
    assign is_xor   = inst.fmt_3r.opcode == OP_XOR;
    assign is_addi  = inst.fmt_2ri12.opcode == OP_ADDI_W;
    assign is_lu12i = inst.fmt_1ri20.opcode == OP_LU12I_W;
    assign is_beq   = inst.fmt_2ri16.opcode == OP_BEQ;
    assign is_bne   = inst.fmt_2ri16.opcode == OP_BNE;
    assign is_b     = inst.fmt_i26.opcode == OP_B;

    assign is_3r     = is_add | is_sub | is_and | is_or | is_xor;
    assign src_is_rd = is_beq | is_bne;

    assign rd = inst.fmt_3r.rd;
    assign rj = inst.fmt_3r.rj;
    assign rk = inst.fmt_3r.rk;

    assign raddr1 = rj;
    assign raddr2 = src_is_rd ? rd : rk;

    regfile regfile_i (
        .clk    (clk),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (byp.commit_fire && byp.we),
        .waddr  (byp.waddr),
        .wdata  (byp.wdata)
    );

    // execute result overrides the file, never for r0
    assign fwd1 = byp.valid && byp.we && (byp.waddr == raddr1) && (raddr1 != '0);
    assign fwd2 = byp.valid && byp.we && (byp.waddr == raddr2) && (raddr2 != '0);

    assign rj_value  = fwd1 ? byp.wdata : rdata1;
    assign rkd_value = fwd2 ? byp.wdata : rdata2;

    assign i26    = {inst.fmt_i26.offs_hi, inst.fmt_i26.offs_lo};
    assign simm12 = {{20{inst.fmt_2ri12.i12[11]}}, inst.fmt_2ri12.i12};
    assign imm20  = {inst.fmt_1ri20.i20, 12'b0};
    assign offs16 = {{14{inst.fmt_2ri16.i16[15]}}, inst.fmt_2ri16.i16, 2'b0};
    assign offs26 = {{4{i26[25]}}, i26, 2'b0};

    always_comb begin
        out.alu_op = ALU_ADD;
        out.src1   = rj_value;
        out.src2   = rkd_value;
        if (is_sub) begin
            out.alu_op = ALU_SUB;
        end else if (is_and) begin
            out.alu_op = ALU_AND;
        end else if (is_or) begin
            out.alu_op = ALU_OR;
        end else if (is_xor) begin
            out.alu_op = ALU_XOR;
        end else if (is_addi) begin
            out.src2 = simm12;
        end else if (is_lu12i) begin
            out.alu_op = ALU_PASS2;
            out.src2   = imm20;
        end
    end

    assign out.valid = valid;
    assign out.pc    = pc;
    // branches and unknown words commit without a write
    assign out.rf_we = is_3r | is_addi | is_lu12i;
    assign out.dest  = rd;

    assign exec_fire = valid && out.allowin;

    assign br_cond = is_b
                   | (is_beq && (rj_value == rkd_value))
                   | (is_bne && (rj_value != rkd_value));

    assign br_redirect = exec_fire && br_cond;
    assign br_target   = pc + (is_b ? offs26 : offs16);

endmodule

// File: hdl/exec_stage.sv
module exec_stage import la_pipe_pkg::*; (
    input  logic              clk,
    input  logic              resetn,
    exec_link_if.consumer     in,
    bypass_if.producer        byp,
    output logic              commit_valid,
    input  logic              commit_ready,
    output logic [XLEN-1:0]   commit_pc,
    output logic              commit_we,
    output logic [REG_AW-1:0] commit_rd,
    output logic [XLEN-1:0]   commit_wdata
);

    logic                valid;
    logic [XLEN-1:0]     pc;
    logic [ALU_OP_W-1:0] alu_op;
    logic [XLEN-1:0]     src1;
    logic [XLEN-1:0]     src2;
    logic                rf_we;
    logic [REG_AW-1:0]   dest;
    logic [XLEN-1:0]     result;

    // holds while commit is back-pressured
    assign in.allowin = !valid || commit_ready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid <= 1'b0;
        end else if (in.allowin) begin
            valid <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid && in.allowin) begin
            pc     <= in.pc;
            alu_op <= in.alu_op;
            src1   <= in.src1;
            src2   <= in.src2;
            rf_we  <= in.rf_we;
            dest   <= in.dest;
        end
    end

    always_comb begin
        case (alu_op)
            ALU_SUB:   result = src1 - src2;
            ALU_AND:   result = src1 & src2;
            ALU_OR:    result = src1 | src2;
            ALU_XOR:   result = src1 ^ src2;
            ALU_PASS2: result = src2;
            default:   result = src1 + src2;
        endcase
    end

    assign commit_valid = valid;
    assign commit_pc    = pc;
    assign commit_we    = rf_we;
    assign commit_rd    = dest;
    assign commit_wdata = result;

    // forwarding view plus write strobe for the file
    assign byp.valid       = valid;
    assign byp.we          = rf_we;
    assign byp.waddr       = dest;
    assign byp.wdata       = result;
    assign byp.commit_fire = valid && commit_ready;

endmodule

// File: hdl/fetch_stage.sv
module fetch_stage import la_pipe_pkg::*; (
    input  logic               clk,
    input  logic               resetn,
    input  logic               fetch_en,
    input  logic               imem_we,
    input  logic [IMEM_AW-1:0] imem_addr,
    input  logic [INST_W-1:0]  imem_wdata,
    input  logic               br_redirect,
    input  logic [XLEN-1:0]    br_target,
    fetch_link_if.producer     out
);

    logic [XLEN-1:0]   pc;
    logic [INST_W-1:0] imem [IMEM_DEPTH];
    logic              fetch_fire;

    // program load port
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    assign out.valid = fetch_en && resetn;
    assign out.pc    = pc;
    // word at current pc, no read latency
    assign out.inst  = imem[pc[IMEM_AW+1:2]];

    assign fetch_fire = out.valid && out.allowin;

    // redirect wins over sequential advance
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc <= '0;
        end else if (br_redirect) begin
            pc <= br_target;
        end else if (fetch_fire) begin
            pc <= pc + PC_STEP;
        end
    end

endmodule

// File: hdl/la_core_top.sv
module la_core_top import la_pipe_pkg::*; (
    input  logic               clk,
    input  logic               resetn,
    input  logic               fetch_en,
    input  logic               imem_we,
    input  logic [IMEM_AW-1:0] imem_addr,
    input  logic [INST_W-1:0]  imem_wdata,
    output logic               commit_valid,
    input  logic               commit_ready,
    output logic [XLEN-1:0]    commit_pc,
    output logic               commit_we,
    output logic [REG_AW-1:0]  commit_rd,
    output logic [XLEN-1:0]    commit_wdata
);

    logic            br_redirect;
    logic [XLEN-1:0] br_target;

    fetch_link_if f_link ();
    exec_link_if  e_link ();
    bypass_if     byp_link ();

    fetch_stage fetch_stage_i (
        .clk         (clk),
        .resetn      (resetn),
        .fetch_en    (fetch_en),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_wdata  (imem_wdata),
        .br_redirect (br_redirect),
        .br_target   (br_target),
        .out         (f_link.producer)
    );

    decode_stage decode_stage_i (
        .clk         (clk),
        .resetn      (resetn),
        .in          (f_link.consumer),
        .out         (e_link.producer),
        .byp         (byp_link.consumer),
        .br_redirect (br_redirect),
        .br_target   (br_target)
    );

    exec_stage exec_stage_i (
        .clk          (clk),
        .resetn       (resetn),
        .in           (e_link.consumer),
        .byp          (byp_link.producer),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit_pc    (commit_pc),
        .commit_we    (commit_we),
        .commit_rd    (commit_rd),
        .commit_wdata (commit_wdata)
    );

endmodule

// File: hdl/la_isa_pkg.sv
package la_isa_pkg;

    // register-register format
    typedef struct packed {
        logic [16:0] opcode;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_3r_t;

    // register plus 12-bit immediate
    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] i12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_2ri12_t;

    // 20-bit immediate, lu12i.w
    typedef struct packed {
        logic [6:0]  opcode;
        logic [19:0] i20;
        logic [4:0]  rd;
    } fmt_1ri20_t;

    // conditional branches
    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] i16;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_2ri16_t;

    // unconditional branch, offset split low part first
    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs_lo;
        logic [9:0]  offs_hi;
    } fmt_i26_t;

    typedef union packed {
        fmt_3r_t    fmt_3r;
        fmt_2ri12_t fmt_2ri12;
        fmt_1ri20_t fmt_1ri20;
        fmt_2ri16_t fmt_2ri16;
        fmt_i26_t   fmt_i26;
    } la_inst_u;

    localparam logic [16:0] OP_ADD_W   = 17'h00020;
    localparam logic [16:0] OP_SUB_W   = 17'h00022;
    localparam logic [16:0] OP_AND     = 17'h00029;
    localparam logic [16:0] OP_OR      = 17'h0002a;
    localparam logic [16:0] OP_XOR     = 17'h0002b;
    localparam logic [9:0]  OP_ADDI_W  = 10'h00a;
    localparam logic [6:0]  OP_LU12I_W = 7'h0a;
    localparam logic [5:0]  OP_BEQ     = 6'h16;
    localparam logic [5:0]  OP_BNE     = 6'h17;
    localparam logic [5:0]  OP_B       = 6'h14;

endpackage

// File: hdl/la_pipe_pkg.sv
package la_pipe_pkg;

    // data path and pc width
    localparam int XLEN = 32;

    // instruction word width
    localparam int INST_W = 32;

    // register file geometry
    localparam int REG_AW = 5;
    localparam int NREGS  = 1 << REG_AW;

    // alu operation encoding
    localparam int ALU_OP_W = 3;

    localparam logic [ALU_OP_W-1:0] ALU_ADD   = 3'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB   = 3'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND   = 3'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR    = 3'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR   = 3'd4;
    localparam logic [ALU_OP_W-1:0] ALU_PASS2 = 3'd5;

    // instruction memory, word address is pc[7:2]
    localparam int IMEM_AW    = 6;
    localparam int IMEM_DEPTH = 1 << IMEM_AW;

    localparam logic [XLEN-1:0] PC_STEP = 32'd4;

endpackage

// File: hdl/regfile.sv
module regfile import la_pipe_pkg::*; (
    input  logic              clk,
    input  logic [REG_AW-1:0] raddr1,
    input  logic [REG_AW-1:0] raddr2,
    output logic [XLEN-1:0]   rdata1,
    output logic [XLEN-1:0]   rdata2,
    input  logic              we,
    input  logic [REG_AW-1:0] waddr,
    input  logic [XLEN-1:0]   wdata
);

    logic [XLEN-1:0] regs [NREGS];

    // r0 never written
    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: hdl/stage_links.sv
interface fetch_link_if import la_pipe_pkg::*; ();
    logic              valid;
    logic              allowin;
    logic [XLEN-1:0]   pc;
    logic [INST_W-1:0] inst;

    modport producer (output valid, pc, inst, input allowin);
    modport consumer (input valid, pc, inst, output allowin);
endinterface

interface exec_link_if import la_pipe_pkg::*; ();
    logic                valid;
    logic                allowin;
    logic [XLEN-1:0]     pc;
    logic [ALU_OP_W-1:0] alu_op;
    logic [XLEN-1:0]     src1;
    logic [XLEN-1:0]     src2;
    logic                rf_we;
    logic [REG_AW-1:0]   dest;

    modport producer (
        output valid, pc, alu_op, src1, src2, rf_we, dest,
        input  allowin
    );
    modport consumer (
        input  valid, pc, alu_op, src1, src2, rf_we, dest,
        output allowin
    );
endinterface

// result held in execute, seen by decode
interface bypass_if import la_pipe_pkg::*; ();
    logic              valid;
    logic              we;
    logic [REG_AW-1:0] waddr;
    logic [XLEN-1:0]   wdata;
    logic              commit_fire;

    modport producer (output valid, we, waddr, wdata, commit_fire);
    modport consumer (input valid, we, waddr, wdata, commit_fire);
endinterface

// File: la_core_top.f
hdl/la_pipe_pkg.sv
hdl/la_isa_pkg.sv
hdl/stage_links.sv
hdl/fetch_stage.sv
hdl/regfile.sv
hdl/decode_stage.sv
hdl/exec_stage.sv
hdl/la_core_top.sv
testbench/la_core_tb.sv

// File: testbench/la_core_tb.sv
module la_core_tb import la_pipe_pkg::*, la_isa_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES   = 10;
    localparam int COMMIT_TIMEOUT = 100;

    logic               clk;
    logic               resetn;
    logic               fetch_en;
    logic               imem_we;
    logic [IMEM_AW-1:0] imem_addr;
    logic [INST_W-1:0]  imem_wdata;
    logic               commit_valid;
    logic               commit_ready;
    logic [XLEN-1:0]    commit_pc;
    logic               commit_we;
    logic [REG_AW-1:0]  commit_rd;
    logic [XLEN-1:0]    commit_wdata;

    logic [31:0] program_words [$];
    logic [31:0] exp_pc [$];
    logic        exp_we [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_wdata [$];

    integer seed;
    integer rnd;
    logic   ready_random = 1'b0;
    int     edge_count = 0;
    int     commit_edge = 0;

    la_core_top la_core_top_i (
        .clk          (clk),
        .resetn       (resetn),
        .fetch_en     (fetch_en),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_wdata   (imem_wdata),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit_pc    (commit_pc),
        .commit_we    (commit_we),
        .commit_rd    (commit_rd),
        .commit_wdata (commit_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        edge_count <= edge_count + 1;
    end

    // random back-pressure for the second run
    always @(posedge clk) begin
        if (ready_random) begin
            rnd = $random(seed);
            commit_ready <= rnd[0];
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("no %s arrived within %0d cycles", what, COMMIT_TIMEOUT);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout waiting for %s", what);
    endtask

    function automatic logic [31:0] enc_3r(input logic [16:0] op, input logic [4:0] rd,
                                           input logic [4:0] rj, input logic [4:0] rk);
        la_inst_u w;
        w = '0;
        w.fmt_3r.opcode = op;
        w.fmt_3r.rk     = rk;
        w.fmt_3r.rj     = rj;
        w.fmt_3r.rd     = rd;
        return w;
    endfunction

    function automatic logic [31:0] enc_2ri12(input logic [4:0] rd, input logic [4:0] rj,
                                              input logic [11:0] i12);
        la_inst_u w;
        w = '0;
        w.fmt_2ri12.opcode = OP_ADDI_W;
        w.fmt_2ri12.i12    = i12;
        w.fmt_2ri12.rj     = rj;
        w.fmt_2ri12.rd     = rd;
        return w;
    endfunction

    function automatic logic [31:0] enc_1ri20(input logic [4:0] rd, input logic [19:0] i20);
        la_inst_u w;
        w = '0;
        w.fmt_1ri20.opcode = OP_LU12I_W;
        w.fmt_1ri20.i20    = i20;
        w.fmt_1ri20.rd     = rd;
        return w;
    endfunction

    function automatic logic [31:0] enc_2ri16(input logic [5:0] op, input logic [4:0] rj,
                                              input logic [4:0] rd, input logic [15:0] i16);
        la_inst_u w;
        w = '0;
        w.fmt_2ri16.opcode = op;
        w.fmt_2ri16.i16    = i16;
        w.fmt_2ri16.rj     = rj;
        w.fmt_2ri16.rd     = rd;
        return w;
    endfunction

    // offset in words
    function automatic logic [31:0] enc_b(input logic [25:0] offs);
        la_inst_u w;
        w = '0;
        w.fmt_i26.opcode  = OP_B;
        w.fmt_i26.offs_lo = offs[15:0];
        w.fmt_i26.offs_hi = offs[25:16];
        return w;
    endfunction

    task automatic add_row(input logic [31:0] pc, input logic we, input logic [4:0] rd,
                           input logic [31:0] wdata);
        exp_pc.push_back(pc);
        exp_we.push_back(we);
        exp_rd.push_back(rd);
        exp_wdata.push_back(wdata);
    endtask

    task automatic build_tables();
        program_words.push_back(enc_2ri12(5'd1, 5'd0, 12'd5));
        program_words.push_back(enc_2ri12(5'd2, 5'd0, 12'hffd));
        program_words.push_back(enc_3r(OP_ADD_W, 5'd3, 5'd1, 5'd2));
        program_words.push_back(enc_3r(OP_SUB_W, 5'd4, 5'd3, 5'd1));
        program_words.push_back(enc_3r(OP_AND, 5'd5, 5'd4, 5'd1));
        program_words.push_back(enc_3r(OP_OR, 5'd6, 5'd5, 5'd2));
        program_words.push_back(enc_3r(OP_XOR, 5'd7, 5'd6, 5'd3));
        program_words.push_back(enc_1ri20(5'd8, 20'habcde));
        // write to r0, then read it back
        program_words.push_back(enc_2ri12(5'd0, 5'd1, 12'd7));
        program_words.push_back(enc_3r(OP_ADD_W, 5'd9, 5'd0, 5'd8));
        program_words.push_back(enc_2ri16(OP_BNE, 5'd1, 5'd5, 16'd4));
        program_words.push_back(enc_2ri16(OP_BEQ, 5'd5, 5'd1, 16'd3));
        program_words.push_back(enc_2ri12(5'd10, 5'd0, 12'd1));
        program_words.push_back(enc_2ri12(5'd11, 5'd0, 12'd2));
        program_words.push_back(enc_3r(OP_ADD_W, 5'd12, 5'd9, 5'd7));
        program_words.push_back(enc_b(26'd2));
        program_words.push_back(enc_2ri12(5'd13, 5'd0, 12'd3));
        program_words.push_back(enc_b(26'd0));

        add_row(32'h00, 1'b1, 5'd1, 32'h0000_0005);
        add_row(32'h04, 1'b1, 5'd2, 32'hffff_fffd);
        add_row(32'h08, 1'b1, 5'd3, 32'h0000_0002);
        add_row(32'h0c, 1'b1, 5'd4, 32'hffff_fffd);
        add_row(32'h10, 1'b1, 5'd5, 32'h0000_0005);
        add_row(32'h14, 1'b1, 5'd6, 32'hffff_fffd);
        add_row(32'h18, 1'b1, 5'd7, 32'hffff_ffff);
        add_row(32'h1c, 1'b1, 5'd8, 32'habcd_e000);
        add_row(32'h20, 1'b1, 5'd0, 32'h0000_000c);
        add_row(32'h24, 1'b1, 5'd9, 32'habcd_e000);
        add_row(32'h28, 1'b0, 5'd0, 32'h0);
        // beq taken, 0x30 and 0x34 skipped
        add_row(32'h2c, 1'b0, 5'd0, 32'h0);
        add_row(32'h38, 1'b1, 5'd12, 32'habcd_dfff);
        add_row(32'h3c, 1'b0, 5'd0, 32'h0);
        add_row(32'h44, 1'b0, 5'd0, 32'h0);
        add_row(32'h44, 1'b0, 5'd0, 32'h0);
        add_row(32'h44, 1'b0, 5'd0, 32'h0);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        resetn   <= 1'b0;
        fetch_en <= 1'b0;
        imem_we  <= 1'b0;
        repeat (RESET_CYCLES - 1) begin
            @(posedge clk);
            @(negedge clk);
            check_value("commit_valid during reset", 32'd0, commit_valid);
        end
        @(posedge clk);
        resetn <= 1'b1;
    endtask

    task automatic load_program();
        int a;
        for (a = 0; a < IMEM_DEPTH; a++) begin
            @(posedge clk);
            imem_we   <= 1'b1;
            imem_addr <= a[IMEM_AW-1:0];
            // unused words decode as no-ops
            imem_wdata <= (a < program_words.size()) ? program_words[a] : (32'hffff_ffc0 | a);
            @(negedge clk);
            check_value("commit_valid before fetch_en", 32'd0, commit_valid);
        end
        @(posedge clk);
        imem_we <= 1'b0;
    endtask

    task automatic wait_commit(input string what);
        int          waited;
        logic        done;
        logic        held;
        logic [31:0] hold_pc;
        logic        hold_we;
        logic [4:0]  hold_rd;
        logic [31:0] hold_wdata;
        waited = 0;
        done   = 1'b0;
        held   = 1'b0;
        while (!done && waited < COMMIT_TIMEOUT) begin
            @(negedge clk);
            // a stalled commit must not move
            if (held) begin
                check_value({what, " held valid"}, 32'd1, commit_valid);
                check_value({what, " held pc"}, hold_pc, commit_pc);
                check_value({what, " held we"}, hold_we, commit_we);
                check_value({what, " held rd"}, hold_rd, commit_rd);
                check_value({what, " held wdata"}, hold_wdata, commit_wdata);
            end
            done       = commit_valid && commit_ready;
            held       = commit_valid;
            hold_pc    = commit_pc;
            hold_we    = commit_we;
            hold_rd    = commit_rd;
            hold_wdata = commit_wdata;
            waited++;
        end
        if (!done) begin
            report_timeout(what);
        end else begin
            commit_edge = edge_count + 1;
        end
    endtask

    task automatic run_program(input logic check_latency);
        int r;
        int sample_edge;
        apply_reset();
        load_program();
        @(posedge clk);
        fetch_en <= 1'b1;
        @(negedge clk);
        sample_edge = edge_count + 1;
        for (r = 0; r < exp_pc.size(); r++) begin
            wait_commit($sformatf("commit for row %0d", r));
            if (check_latency && r == 0) begin
                check_value("first commit latency", 32'd2, commit_edge - sample_edge);
            end
            check_value($sformatf("row %0d pc", r), exp_pc[r], commit_pc);
            check_value($sformatf("row %0d we", r), exp_we[r], commit_we);
            if (exp_we[r]) begin
                check_value($sformatf("row %0d rd", r), exp_rd[r], commit_rd);
                check_value($sformatf("row %0d wdata", r), exp_wdata[r], commit_wdata);
            end
        end
    endtask

    initial begin
        resetn       = 1'b0;
        fetch_en     = 1'b0;
        imem_we      = 1'b0;
        imem_addr    = '0;
        imem_wdata   = '0;
        commit_ready = 1'b1;
        seed         = 71338;
        build_tables();
        run_program(1'b1);
        // second pass with commit_ready toggling
        @(negedge clk);
        ready_random = 1'b1;
        run_program(1'b0);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
